/* hw/vizPkg.sv */
package vizPkg;

	// meter and bar counts
	localparam int NUM_BARS = 4;
	localparam int NUM_SEGS = 6;
	// segments first, then one marker per bar
	localparam int NUM_LAYERS = NUM_BARS * NUM_SEGS + NUM_BARS;
	localparam int WINDOW_LEN = 64;

	// datapath widths
	localparam int SAMPLE_W = 16;
	localparam int LEVEL_W = 16;
	localparam int X_W = 10;
	localparam int Y_W = 9;
	localparam int APB_ADDR_W = 8;
	localparam int APB_DATA_W = 32;
	localparam int CTRL_W = 8;

	// bar columns in pixels
	localparam int BAR_X0 = 40;
	localparam int BAR_PITCH = 150;
	localparam int BAR_WIDTH = 100;

	// segment rows, segment 0 at the bottom
	localparam int SEG_Y0 = 40;
	localparam int SEG_PITCH = 70;
	localparam int SEG_HEIGHT = 60;
	localparam int MARKER_ROWS = 4;

	// register map
	localparam logic [APB_ADDR_W-1:0] ADDR_CTRL = 8'h00;
	localparam logic [APB_ADDR_W-1:0] ADDR_STEP = 8'h04;
	localparam logic [APB_ADDR_W-1:0] ADDR_BG = 8'h08;
	localparam logic [APB_ADDR_W-1:0] ADDR_MARKER = 8'h0C;
	localparam logic [APB_ADDR_W-1:0] ADDR_BAR0 = 8'h10;
	localparam logic [APB_ADDR_W-1:0] ADDR_BAR1 = 8'h14;
	localparam logic [APB_ADDR_W-1:0] ADDR_BAR2 = 8'h18;
	localparam logic [APB_ADDR_W-1:0] ADDR_BAR3 = 8'h1C;
	localparam logic [APB_ADDR_W-1:0] ADDR_CLEAR = 8'h20;
	localparam logic [APB_ADDR_W-1:0] ADDR_LEVEL0 = 8'h24;
	localparam logic [APB_ADDR_W-1:0] ADDR_LEVEL1 = 8'h28;
	localparam logic [APB_ADDR_W-1:0] ADDR_LEVEL2 = 8'h2C;
	localparam logic [APB_ADDR_W-1:0] ADDR_LEVEL3 = 8'h30;

	// reset values, ctrl bit 0 display on, bits 7:4 bar mask
	localparam logic [CTRL_W-1:0] RST_CTRL = 8'hF1;
	localparam logic [LEVEL_W-1:0] RST_STEP = 16'h1388;
	localparam logic [APB_DATA_W-1:0] RST_BG = 32'h0000_0000;
	localparam logic [APB_DATA_W-1:0] RST_MARKER = 32'h00FF_FFFF;
	localparam logic [APB_DATA_W-1:0] RST_BAR0 = 32'h0000_FF00;
	localparam logic [APB_DATA_W-1:0] RST_BAR1 = 32'h0000_C0FF;
	localparam logic [APB_DATA_W-1:0] RST_BAR2 = 32'h00FF_C000;
	localparam logic [APB_DATA_W-1:0] RST_BAR3 = 32'h00FF_4040;

	// colour register word, raw on the bus, rgb bytes in the mixer
	typedef union packed {
		logic [APB_DATA_W-1:0] raw;
		struct packed {
			logic [7:0] pad;
			logic [7:0] red;
			logic [7:0] green;
			logic [7:0] blue;
		} rgb;
	} colorWord_t;

endpackage

/* hw/levelMeter.sv */
`timescale 1ns/100ps

module levelMeter (
	input  logic                                clk,
	input  logic                                arstN,
	input  logic signed [vizPkg::SAMPLE_W-1:0] sample,
	input  logic                                sampleValid,
	input  logic                                peakClear,
	output logic        [vizPkg::LEVEL_W-1:0]  level,
	output logic        [vizPkg::LEVEL_W-1:0]  peak
);

	localparam int CNT_W = $clog2(vizPkg::WINDOW_LEN);
	// most negative sample has no positive twin
	localparam logic signed [vizPkg::SAMPLE_W-1:0] SAMPLE_MIN =
		{1'b1, {(vizPkg::SAMPLE_W-1){1'b0}}};
	localparam logic [vizPkg::LEVEL_W-1:0] ABS_MAX =
		vizPkg::LEVEL_W'((1 << (vizPkg::SAMPLE_W - 1)) - 1);

	logic [CNT_W-1:0] sampleCnt;
	logic [vizPkg::LEVEL_W-1:0] runMax;
	logic [vizPkg::LEVEL_W-1:0] absVal;
	logic [vizPkg::LEVEL_W-1:0] newMax;
	logic windowEnd;

	// saturating magnitude
	always_comb begin
		if (sample == SAMPLE_MIN) begin
			absVal = ABS_MAX;
		end else if (sample < 0) begin
			absVal = vizPkg::LEVEL_W'(-sample);
		end else begin
			absVal = vizPkg::LEVEL_W'(sample);
		end
	end

	// running max including this sample
	assign newMax = (absVal > runMax) ? absVal : runMax;
	// last sample of the window
	assign windowEnd = sampleValid && (sampleCnt == CNT_W'(vizPkg::WINDOW_LEN - 1));

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			sampleCnt <= '0;
			runMax <= '0;
			level <= '0;
		end else if (sampleValid) begin
			// counter wraps on its own at the window length
			sampleCnt <= sampleCnt + 1'b1;
			if (windowEnd) begin
				level <= newMax;
				runMax <= '0;
			end else begin
				runMax <= newMax;
			end
		end
	end

	// held peak, clear loses to a same-cycle window result
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			peak <= '0;
		end else if (windowEnd) begin
			if (peakClear || (newMax > peak)) begin
				peak <= newMax;
			end
		end else if (peakClear) begin
			peak <= '0;
		end
	end

endmodule

/* hw/barSegments.sv */
`timescale 1ns/100ps

module barSegments #(
	parameter int barIndex = 0
) (
	input  logic                           clk,
	input  logic                           arstN,
	input  logic [vizPkg::X_W-1:0]        pixelX,
	input  logic [vizPkg::Y_W-1:0]        pixelY,
	input  logic [vizPkg::LEVEL_W-1:0]    level,
	input  logic [vizPkg::LEVEL_W-1:0]    peak,
	input  logic [vizPkg::LEVEL_W-1:0]    step,
	input  logic                           barOn,
	output logic [vizPkg::NUM_SEGS-1:0]   segHit,
	output logic                           markerHit
);

	// room for NUM_SEGS times a full scale step
	localparam int THR_W = vizPkg::LEVEL_W + 3;
	localparam logic [vizPkg::X_W-1:0] X_START =
		vizPkg::X_W'(vizPkg::BAR_X0 + barIndex * vizPkg::BAR_PITCH);
	localparam logic [vizPkg::X_W-1:0] X_END =
		vizPkg::X_W'(vizPkg::BAR_X0 + barIndex * vizPkg::BAR_PITCH + vizPkg::BAR_WIDTH);

	logic inBar;
	logic [vizPkg::NUM_SEGS-1:0] inSegY;
	logic [vizPkg::NUM_SEGS-1:0] inMarkY;
	logic [vizPkg::NUM_SEGS-1:0] levelReach;
	logic [vizPkg::NUM_SEGS-1:0] segNext;
	logic [$clog2(vizPkg::NUM_SEGS)-1:0] peakSeg;
	logic peakFound;
	logic markerNext;

	// column test, end exclusive
	assign inBar = (pixelX >= X_START) && (pixelX < X_END);

	// per segment row windows and thresholds
	always_comb begin
		logic [vizPkg::Y_W-1:0] segTop;
		logic [THR_W-1:0] thr;
		inSegY = '0;
		inMarkY = '0;
		levelReach = '0;
		peakSeg = '0;
		peakFound = 1'b0;
		for (int j = 0; j < vizPkg::NUM_SEGS; j++) begin
			// segment 0 sits lowest on screen
			segTop = vizPkg::Y_W'(vizPkg::SEG_Y0 + (vizPkg::NUM_SEGS - 1 - j) * vizPkg::SEG_PITCH);
			thr = THR_W'(step) * THR_W'(j + 1);
			inSegY[j] = (pixelY >= segTop) &&
				(pixelY < segTop + vizPkg::Y_W'(vizPkg::SEG_HEIGHT));
			inMarkY[j] = (pixelY >= segTop) &&
				(pixelY < segTop + vizPkg::Y_W'(vizPkg::MARKER_ROWS));
			levelReach[j] = (THR_W'(level) >= thr);
			// ascending scan keeps the highest reached segment
			if (THR_W'(peak) >= thr) begin
				peakSeg = ($clog2(vizPkg::NUM_SEGS))'(j);
				peakFound = 1'b1;
			end
		end
	end

	assign segNext = (barOn && inBar) ? (inSegY & levelReach) : '0;
	// no marker until the peak clears the first step
	assign markerNext = barOn && inBar && peakFound && inMarkY[peakSeg];

	// stage 1 of the pixel pipe
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			segHit <= '0;
			markerHit <= 1'b0;
		end else begin
			segHit <= segNext;
			markerHit <= markerNext;
		end
	end

endmodule

/* hw/layerMixer.sv */
`timescale 1ns/100ps

module layerMixer (
	input  logic                             clk,
	input  logic                             arstN,
	input  logic [vizPkg::NUM_LAYERS-1:0]   layers,
	input  vizPkg::colorWord_t               barColor0,
	input  vizPkg::colorWord_t               barColor1,
	input  vizPkg::colorWord_t               barColor2,
	input  vizPkg::colorWord_t               barColor3,
	input  vizPkg::colorWord_t               markerColor,
	input  vizPkg::colorWord_t               bgColor,
	input  logic                             displayOn,
	input  logic                             validIn,
	output logic [7:0]                       red,
	output logic [7:0]                       green,
	output logic [7:0]                       blue,
	output logic                             validOut
);

	localparam int NUM_SEG_LAYERS = vizPkg::NUM_BARS * vizPkg::NUM_SEGS;

	vizPkg::colorWord_t barColors [vizPkg::NUM_BARS];
	vizPkg::colorWord_t pick;

	assign barColors[0] = barColor0;
	assign barColors[1] = barColor1;
	assign barColors[2] = barColor2;
	assign barColors[3] = barColor3;

	// priority search, later hits win
	always_comb begin
		pick = bgColor;
		for (int i = 0; i < vizPkg::NUM_LAYERS; i++) begin
			if (layers[i]) begin
				// markers sit above every segment
				if (i >= NUM_SEG_LAYERS) begin
					pick = markerColor;
				end else begin
					pick = barColors[i / vizPkg::NUM_SEGS];
				end
			end
		end
	end

	// stage 2, display off forces black
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			red <= '0;
			green <= '0;
			blue <= '0;
			validOut <= 1'b0;
		end else begin
			validOut <= validIn;
			if (displayOn) begin
				red <= pick.rgb.red;
				green <= pick.rgb.green;
				blue <= pick.rgb.blue;
			end else begin
				red <= '0;
				green <= '0;
				blue <= '0;
			end
		end
	end

endmodule

/* hw/vizRegs.sv */
`timescale 1ns/100ps

module vizRegs (
	input  logic                              clk,
	input  logic                              arstN,
	input  logic [vizPkg::APB_ADDR_W-1:0]    paddr,
	input  logic                              psel,
	input  logic                              penable,
	input  logic                              pwrite,
	input  logic [vizPkg::APB_DATA_W-1:0]    pwdata,
	output logic [vizPkg::APB_DATA_W-1:0]    prdata,
	output logic                              pready,
	output logic                              pslverr,
	input  logic [vizPkg::LEVEL_W-1:0]       level0,
	input  logic [vizPkg::LEVEL_W-1:0]       level1,
	input  logic [vizPkg::LEVEL_W-1:0]       level2,
	input  logic [vizPkg::LEVEL_W-1:0]       level3,
	input  logic [vizPkg::LEVEL_W-1:0]       peak0,
	input  logic [vizPkg::LEVEL_W-1:0]       peak1,
	input  logic [vizPkg::LEVEL_W-1:0]       peak2,
	input  logic [vizPkg::LEVEL_W-1:0]       peak3,
	output logic                              displayOn,
	output logic [vizPkg::NUM_BARS-1:0]      barMask,
	output logic [vizPkg::LEVEL_W-1:0]       step,
	output vizPkg::colorWord_t                bgColor,
	output vizPkg::colorWord_t                markerColor,
	output vizPkg::colorWord_t                barColor0,
	output vizPkg::colorWord_t                barColor1,
	output vizPkg::colorWord_t                barColor2,
	output vizPkg::colorWord_t                barColor3,
	output logic                              peakClear
);

	logic [vizPkg::CTRL_W-1:0] ctrlReg;
	logic access;
	logic mapped;
	logic readOnly;
	logic writeOnly;
	logic wrEn;

	// no wait states
	assign pready = 1'b1;
	assign access = psel && penable;

	assign displayOn = ctrlReg[0];
	assign barMask = ctrlReg[vizPkg::CTRL_W-1 -: vizPkg::NUM_BARS];

	// read mux and address class, both from paddr alone
	always_comb begin
		prdata = '0;
		mapped = 1'b1;
		readOnly = 1'b0;
		writeOnly = 1'b0;
		case (paddr)
			vizPkg::ADDR_CTRL: prdata = vizPkg::APB_DATA_W'(ctrlReg);
			vizPkg::ADDR_STEP: prdata = vizPkg::APB_DATA_W'(step);
			vizPkg::ADDR_BG: prdata = bgColor.raw;
			vizPkg::ADDR_MARKER: prdata = markerColor.raw;
			vizPkg::ADDR_BAR0: prdata = barColor0.raw;
			vizPkg::ADDR_BAR1: prdata = barColor1.raw;
			vizPkg::ADDR_BAR2: prdata = barColor2.raw;
			vizPkg::ADDR_BAR3: prdata = barColor3.raw;
			// clear is a strobe, nothing to read
			vizPkg::ADDR_CLEAR: writeOnly = 1'b1;
			// peak high half, level low half
			vizPkg::ADDR_LEVEL0: begin
				prdata = {peak0, level0};
				readOnly = 1'b1;
			end
			vizPkg::ADDR_LEVEL1: begin
				prdata = {peak1, level1};
				readOnly = 1'b1;
			end
			vizPkg::ADDR_LEVEL2: begin
				prdata = {peak2, level2};
				readOnly = 1'b1;
			end
			vizPkg::ADDR_LEVEL3: begin
				prdata = {peak3, level3};
				readOnly = 1'b1;
			end
			default: mapped = 1'b0;
		endcase
	end

	assign pslverr = access && (!mapped || (pwrite && readOnly) || (!pwrite && writeOnly));
	// errored writes are dropped
	assign wrEn = access && pwrite && !pslverr;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			ctrlReg <= vizPkg::RST_CTRL;
			step <= vizPkg::RST_STEP;
			bgColor.raw <= vizPkg::RST_BG;
			markerColor.raw <= vizPkg::RST_MARKER;
			barColor0.raw <= vizPkg::RST_BAR0;
			barColor1.raw <= vizPkg::RST_BAR1;
			barColor2.raw <= vizPkg::RST_BAR2;
			barColor3.raw <= vizPkg::RST_BAR3;
			peakClear <= 1'b0;
		end else begin
			// one cycle pulse on a clear write with bit 0 set
			peakClear <= wrEn && (paddr == vizPkg::ADDR_CLEAR) && pwdata[0];
			if (wrEn) begin
				case (paddr)
					vizPkg::ADDR_CTRL: ctrlReg <= pwdata[vizPkg::CTRL_W-1:0];
					vizPkg::ADDR_STEP: step <= pwdata[vizPkg::LEVEL_W-1:0];
					vizPkg::ADDR_BG: bgColor.raw <= pwdata;
					vizPkg::ADDR_MARKER: markerColor.raw <= pwdata;
					vizPkg::ADDR_BAR0: barColor0.raw <= pwdata;
					vizPkg::ADDR_BAR1: barColor1.raw <= pwdata;
					vizPkg::ADDR_BAR2: barColor2.raw <= pwdata;
					vizPkg::ADDR_BAR3: barColor3.raw <= pwdata;
					default: ;
				endcase
			end
		end
	end

endmodule

/* hw/spectrumVisualizer.sv */
`timescale 1ns/100ps

module spectrumVisualizer (
	input  logic                                clk,
	input  logic                                arstN,
	input  logic [vizPkg::APB_ADDR_W-1:0]      paddr,
	input  logic                                psel,
	input  logic                                penable,
	input  logic                                pwrite,
	input  logic [vizPkg::APB_DATA_W-1:0]      pwdata,
	output logic [vizPkg::APB_DATA_W-1:0]      prdata,
	output logic                                pready,
	output logic                                pslverr,
	input  logic signed [vizPkg::SAMPLE_W-1:0] sampleL,
	input  logic signed [vizPkg::SAMPLE_W-1:0] sampleR,
	input  logic                                sampleValid,
	input  logic [vizPkg::X_W-1:0]             pixelX,
	input  logic [vizPkg::Y_W-1:0]             pixelY,
	input  logic                                pixelValid,
	output logic [7:0]                          red,
	output logic [7:0]                          green,
	output logic [7:0]                          blue,
	output logic                                pixelOutValid
);

	// one extra bit so the sum cannot wrap
	logic signed [vizPkg::SAMPLE_W:0] midSum;
	logic signed [vizPkg::SAMPLE_W:0] sideDiff;
	logic signed [vizPkg::SAMPLE_W-1:0] chSample [vizPkg::NUM_BARS];
	logic [vizPkg::LEVEL_W-1:0] level [vizPkg::NUM_BARS];
	logic [vizPkg::LEVEL_W-1:0] peak [vizPkg::NUM_BARS];
	logic [vizPkg::NUM_SEGS-1:0] segHit [vizPkg::NUM_BARS];
	logic [vizPkg::NUM_BARS-1:0] markerHit;
	logic [vizPkg::NUM_LAYERS-1:0] layers;
	logic [vizPkg::NUM_BARS-1:0] barMask;
	logic [vizPkg::LEVEL_W-1:0] step;
	logic displayOn;
	logic peakClear;
	logic pixelValidD;
	vizPkg::colorWord_t bgColor;
	vizPkg::colorWord_t markerColor;
	vizPkg::colorWord_t barColor0;
	vizPkg::colorWord_t barColor1;
	vizPkg::colorWord_t barColor2;
	vizPkg::colorWord_t barColor3;

	// mid and side, arithmetic halves
	assign midSum = sampleL + sampleR;
	assign sideDiff = sampleL - sampleR;

	// meter order L, R, mid, side
	assign chSample[0] = sampleL;
	assign chSample[1] = sampleR;
	assign chSample[2] = midSum[vizPkg::SAMPLE_W:1];
	assign chSample[3] = sideDiff[vizPkg::SAMPLE_W:1];

	vizRegs regs (
		.clk(clk), .arstN(arstN),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.level0(level[0]), .level1(level[1]), .level2(level[2]), .level3(level[3]),
		.peak0(peak[0]), .peak1(peak[1]), .peak2(peak[2]), .peak3(peak[3]),
		.displayOn(displayOn), .barMask(barMask), .step(step),
		.bgColor(bgColor), .markerColor(markerColor),
		.barColor0(barColor0), .barColor1(barColor1),
		.barColor2(barColor2), .barColor3(barColor3),
		.peakClear(peakClear)
	);

	// one meter and one bar per channel
	for (genvar b = 0; b < vizPkg::NUM_BARS; b++) begin : gBar
		levelMeter meter (
			.clk(clk), .arstN(arstN),
			.sample(chSample[b]), .sampleValid(sampleValid), .peakClear(peakClear),
			.level(level[b]), .peak(peak[b])
		);

		barSegments #(.barIndex(b)) bar (
			.clk(clk), .arstN(arstN),
			.pixelX(pixelX), .pixelY(pixelY),
			.level(level[b]), .peak(peak[b]), .step(step), .barOn(barMask[b]),
			.segHit(segHit[b]), .markerHit(markerHit[b])
		);

		// segments b*6.., markers after all segments
		assign layers[b * vizPkg::NUM_SEGS +: vizPkg::NUM_SEGS] = segHit[b];
		assign layers[vizPkg::NUM_BARS * vizPkg::NUM_SEGS + b] = markerHit[b];
	end

	// valid tracks the stage 1 registers
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pixelValidD <= 1'b0;
		end else begin
			pixelValidD <= pixelValid;
		end
	end

	layerMixer mixer (
		.clk(clk), .arstN(arstN),
		.layers(layers),
		.barColor0(barColor0), .barColor1(barColor1),
		.barColor2(barColor2), .barColor3(barColor3),
		.markerColor(markerColor), .bgColor(bgColor),
		.displayOn(displayOn), .validIn(pixelValidD),
		.red(red), .green(green), .blue(blue), .validOut(pixelOutValid)
	);

endmodule

/* tests/spectrumVisualizerTb.sv */
`timescale 1ns/100ps

module spectrumVisualizerTb;

	localparam int CLK_PERIOD = 8;
	// 3 loud, 1 quiet, 1 after clear
	localparam int NUM_WINDOWS = 5;
	localparam int NUM_SAMPLES = NUM_WINDOWS * vizPkg::WINDOW_LEN;
	// 4 x probes by 6 y probes per segment
	localparam int PIXELS_PER_SCAN = vizPkg::NUM_BARS * vizPkg::NUM_SEGS * 24;
	localparam int NUM_SCANS = 6;
	localparam int NUM_APB = 100;
	localparam int WATCHDOG_NS =
		(NUM_SAMPLES + NUM_SCANS * PIXELS_PER_SCAN + NUM_APB) * CLK_PERIOD * 2;

	logic clk;
	logic arstN;
	logic [vizPkg::APB_ADDR_W-1:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [vizPkg::APB_DATA_W-1:0] pwdata;
	logic [vizPkg::APB_DATA_W-1:0] prdata;
	logic pready;
	logic pslverr;
	logic signed [vizPkg::SAMPLE_W-1:0] sampleL;
	logic signed [vizPkg::SAMPLE_W-1:0] sampleR;
	logic sampleValid;
	logic [vizPkg::X_W-1:0] pixelX;
	logic [vizPkg::Y_W-1:0] pixelY;
	logic pixelValid;
	logic [7:0] red;
	logic [7:0] green;
	logic [7:0] blue;
	logic pixelOutValid;

	integer seed;
	// ctrl, step, bg, marker, bar0..bar3 as read back
	logic [31:0] regModel [8];
	logic [15:0] modelLevel [4];
	logic [15:0] modelPeak [4];
	logic [15:0] modelRun [4];
	int modelCnt;
	logic [23:0] expQ [$];
	logic [23:0] expRgb;

	spectrumVisualizer UUT (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic stopOnError(input string msg);
		$display("%s", msg);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else stopOnError($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	// output valid trails input valid by the two pipe stages
	assert property (@(posedge clk) disable iff (!arstN) pixelOutValid == $past(pixelValid, 2))
	else stopOnError($sformatf("FAIL pixelOutValid got 0x%h expected 0x%h",
		$sampled(pixelOutValid), !$sampled(pixelOutValid)));

	assert property (@(posedge clk) disable iff (!arstN) pready)
	else stopOnError("pready went low although the APB slave has no wait states");

	// compare every returned pixel at the falling edge
	always @(negedge clk) begin
		if (arstN && pixelOutValid) begin
			if (expQ.size() == 0) begin
				stopOnError("a pixel came out with no pixel in flight");
			end else begin
				expRgb = expQ.pop_front();
				checkEq("{red,green,blue}", {8'h0, red, green, blue}, {8'h0, expRgb});
			end
		end
	end

	task automatic apbAccess(input logic [7:0] addr, input logic write, input logic [31:0] wdata,
			input logic expErr, output logic [31:0] rdata);
		int waitCycles;
		// setup phase
		@(posedge clk);
		#1;
		paddr = addr;
		pwrite = write;
		pwdata = wdata;
		psel = 1'b1;
		penable = 1'b0;
		// access phase, sample once settled
		@(posedge clk);
		#1;
		penable = 1'b1;
		#1;
		waitCycles = 0;
		while (!pready) begin
			@(posedge clk);
			#2;
			waitCycles++;
			if (waitCycles > 16) stopOnError("APB transfer never saw pready");
		end
		checkEq($sformatf("pslverr@%h", addr), 32'(pslverr), 32'(expErr));
		rdata = prdata;
		@(posedge clk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data, input logic expErr);
		logic [31:0] rdataIgnored;
		apbAccess(addr, 1'b1, data, expErr, rdataIgnored);
		if (!expErr) begin
			// ctrl keeps 8 bits, step 16 bits
			if (addr == vizPkg::ADDR_CTRL) begin
				regModel[0] = {24'h0, data[7:0]};
			end else if (addr == vizPkg::ADDR_STEP) begin
				regModel[1] = {16'h0, data[15:0]};
			end else if (addr < vizPkg::ADDR_CLEAR) begin
				regModel[addr >> 2] = data;
			end else if (addr == vizPkg::ADDR_CLEAR && data[0]) begin
				foreach (modelPeak[c]) modelPeak[c] = '0;
			end
		end
	endtask

	task automatic apbRead(input logic [7:0] addr, input logic [31:0] expData, input logic expErr);
		logic [31:0] rdata;
		apbAccess(addr, 1'b0, 32'h0, expErr, rdata);
		if (!expErr) checkEq($sformatf("prdata@%h", addr), rdata, expData);
	endtask

	task automatic checkAllRegs();
		for (int i = 0; i < 8; i++) apbRead(8'(i * 4), regModel[i], 1'b0);
	endtask

	// peak high half, level low half
	task automatic checkLevels();
		for (int c = 0; c < 4; c++) begin
			apbRead(8'(vizPkg::ADDR_LEVEL0 + 4 * c), {modelPeak[c], modelLevel[c]}, 1'b0);
		end
	endtask

	function automatic logic [15:0] magnitude(input logic signed [15:0] v);
		// -32768 saturates
		if (v == 16'sh8000) return 16'h7FFF;
		if (v < 0) return -v;
		return v;
	endfunction

	task automatic modelSample(input logic signed [15:0] l, input logic signed [15:0] r);
		logic signed [16:0] sum;
		logic signed [16:0] diff;
		logic signed [15:0] ch [4];
		logic [15:0] mag;
		sum = l + r;
		diff = l - r;
		ch[0] = l;
		ch[1] = r;
		// halves taken at 17 bits
		ch[2] = 16'(sum >>> 1);
		ch[3] = 16'(diff >>> 1);
		modelCnt++;
		for (int c = 0; c < 4; c++) begin
			mag = magnitude(ch[c]);
			if (mag > modelRun[c]) modelRun[c] = mag;
			if (modelCnt == vizPkg::WINDOW_LEN) begin
				modelLevel[c] = modelRun[c];
				if (modelRun[c] > modelPeak[c]) modelPeak[c] = modelRun[c];
				modelRun[c] = '0;
			end
		end
		if (modelCnt == vizPkg::WINDOW_LEN) modelCnt = 0;
	endtask

	// shift scales the random samples down
	task automatic sendWindows(input int windows, input int shift);
		logic signed [15:0] l;
		logic signed [15:0] r;
		for (int n = 0; n < windows * vizPkg::WINDOW_LEN; n++) begin
			@(posedge clk);
			#1;
			// idle cycle now and then, meters hold
			if (($random(seed) & 3) == 0) begin
				sampleValid = 1'b0;
				@(posedge clk);
				#1;
			end
			l = $random(seed);
			r = $random(seed);
			l = l >>> shift;
			r = r >>> shift;
			// most negative code on loud windows, both at once for mid
			if (shift == 0 && (n % 29 == 3 || n % 64 == 20)) l = 16'sh8000;
			if (shift == 0 && (n % 41 == 7 || n % 64 == 20)) r = 16'sh8000;
			sampleL = l;
			sampleR = r;
			sampleValid = 1'b1;
			modelSample(l, r);
		end
		@(posedge clk);
		#1;
		sampleValid = 1'b0;
	endtask

	function automatic logic [23:0] modelColor(input int x, input int y);
		logic [23:0] c;
		int x0;
		int top;
		int stp;
		int k;
		stp = int'(regModel[1][15:0]);
		c = regModel[2][23:0];
		// segment layers b*6+j, later ones win
		for (int b = 0; b < vizPkg::NUM_BARS; b++) begin
			x0 = vizPkg::BAR_X0 + b * vizPkg::BAR_PITCH;
			if (regModel[0][4 + b] && x >= x0 && x < x0 + vizPkg::BAR_WIDTH) begin
				for (int j = 0; j < vizPkg::NUM_SEGS; j++) begin
					top = vizPkg::SEG_Y0 + (5 - j) * vizPkg::SEG_PITCH;
					if (y >= top && y < top + vizPkg::SEG_HEIGHT &&
						int'(modelLevel[b]) >= (j + 1) * stp) c = regModel[4 + b][23:0];
				end
			end
		end
		// markers outrank every segment
		for (int b = 0; b < vizPkg::NUM_BARS; b++) begin
			x0 = vizPkg::BAR_X0 + b * vizPkg::BAR_PITCH;
			k = -1;
			for (int j = 0; j < vizPkg::NUM_SEGS; j++) begin
				if (int'(modelPeak[b]) >= (j + 1) * stp) k = j;
			end
			top = vizPkg::SEG_Y0 + (5 - k) * vizPkg::SEG_PITCH;
			if (regModel[0][4 + b] && x >= x0 && x < x0 + vizPkg::BAR_WIDTH && k >= 0 &&
				y >= top && y < top + vizPkg::MARKER_ROWS) c = regModel[3][23:0];
		end
		if (!regModel[0][0]) c = 24'h0;
		return c;
	endfunction

	// probes on column edges, segment edges and the marker band edge
	task automatic scanBars();
		int xs [4];
		int ys [6];
		int x0;
		int top;
		for (int b = 0; b < vizPkg::NUM_BARS; b++) begin
			for (int j = 0; j < vizPkg::NUM_SEGS; j++) begin
				x0 = vizPkg::BAR_X0 + b * vizPkg::BAR_PITCH;
				top = vizPkg::SEG_Y0 + (5 - j) * vizPkg::SEG_PITCH;
				xs = '{x0 - 1, x0, x0 + vizPkg::BAR_WIDTH - 1, x0 + vizPkg::BAR_WIDTH};
				ys = '{top - 1, top, top + vizPkg::MARKER_ROWS - 1, top + vizPkg::MARKER_ROWS,
					top + vizPkg::SEG_HEIGHT - 1, top + vizPkg::SEG_HEIGHT};
				for (int xi = 0; xi < 4; xi++) begin
					for (int yi = 0; yi < 6; yi++) begin
						@(posedge clk);
						#1;
						// bubble in the pixel stream
						if (($random(seed) & 7) == 0) begin
							pixelValid = 1'b0;
							@(posedge clk);
							#1;
						end
						pixelX = 10'(xs[xi]);
						pixelY = 9'(ys[yi]);
						pixelValid = 1'b1;
						expQ.push_back(modelColor(xs[xi], ys[yi]));
					end
				end
			end
		end
		@(posedge clk);
		#1;
		pixelValid = 1'b0;
		for (int i = 0; i < 8 && expQ.size() != 0; i++) @(posedge clk);
		if (expQ.size() != 0) stopOnError("pixel pipeline did not return every pixel");
	endtask

	initial begin
		#(WATCHDOG_NS);
		stopOnError("timeout, the run did not finish within the watchdog limit");
	end

	initial begin
		seed = 32'h526c;
		arstN = 1'b0;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		sampleL = '0;
		sampleR = '0;
		sampleValid = 1'b0;
		pixelX = '0;
		pixelY = '0;
		pixelValid = 1'b0;
		regModel = '{32'hF1, 32'h1388, 32'h0, 32'hFF_FFFF,
			32'h00_FF00, 32'h00_C0FF, 32'hFF_C000, 32'hFF_4040};
		foreach (modelLevel[c]) begin
			modelLevel[c] = '0;
			modelPeak[c] = '0;
			modelRun[c] = '0;
		end
		modelCnt = 0;
		repeat (8) @(posedge clk);
		#1;
		arstN = 1'b1;

		// reset values, then random write and readback
		checkAllRegs();
		checkLevels();
		for (int i = 0; i < 8; i++) apbWrite(8'(i * 4), $random(seed), 1'b0);
		checkAllRegs();
		// unmapped, level write, clear read
		apbWrite(8'h34, 32'hDEAD_BEEF, 1'b1);
		apbRead(8'h40, 32'h0, 1'b1);
		apbWrite(vizPkg::ADDR_LEVEL2, 32'hFFFF_FFFF, 1'b1);
		apbRead(vizPkg::ADDR_CLEAR, 32'h0, 1'b1);
		checkAllRegs();
		checkLevels();

		// display setup, pad bytes must not leak into rgb
		apbWrite(vizPkg::ADDR_CTRL, 32'hF1, 1'b0);
		apbWrite(vizPkg::ADDR_STEP, 32'h1388, 1'b0);
		apbWrite(vizPkg::ADDR_BG, 32'hAB10_2030, 1'b0);
		apbWrite(vizPkg::ADDR_MARKER, 32'h55F0_E0D0, 1'b0);
		apbWrite(vizPkg::ADDR_BAR0, 32'h0000_FF00, 1'b0);
		apbWrite(vizPkg::ADDR_BAR1, 32'h7700_C0FF, 1'b0);
		apbWrite(vizPkg::ADDR_BAR2, 32'h00FF_C000, 1'b0);
		apbWrite(vizPkg::ADDR_BAR3, 32'h00FF_4040, 1'b0);

		// loud windows with full scale codes
		sendWindows(3, 0);
		checkLevels();
		scanBars();
		// quiet window, marker stays up high
		sendWindows(1, 2);
		checkLevels();
		scanBars();
		// clear, then the next window sets the peak
		apbWrite(vizPkg::ADDR_CLEAR, 32'h1, 1'b0);
		checkLevels();
		sendWindows(1, 2);
		checkLevels();
		scanBars();
		// coarser step
		apbWrite(vizPkg::ADDR_STEP, 32'h1800, 1'b0);
		scanBars();
		// bars 1 and 3 off
		apbWrite(vizPkg::ADDR_CTRL, 32'h51, 1'b0);
		scanBars();
		// display off
		apbWrite(vizPkg::ADDR_CTRL, 32'hF0, 1'b0);
		scanBars();

		if (expQ.size() == 0) begin
			$display("All checks passed");
			$finish;
		end else begin
			stopOnError("expected pixels left over at the end of the run");
		end
	end

endmodule

/* spectrumVisualizer.f */
hw/vizPkg.sv
hw/levelMeter.sv
hw/barSegments.sv
hw/layerMixer.sv
hw/vizRegs.sv
hw/spectrumVisualizer.sv
tests/spectrumVisualizerTb.sv

/* Bender.yml */
package:
  name: spectrum_visualizer

sources:
  - hw/vizPkg.sv
  - hw/levelMeter.sv
  - hw/barSegments.sv
  - hw/layerMixer.sv
  - hw/vizRegs.sv
  - hw/spectrumVisualizer.sv
  - target: test
    files:
      - tests/spectrumVisualizerTb.sv
